//--- Makefile
# Verilator build and run for the timed command sequencer

VERILATOR ?= verilator
TOP       ?= tb_timed_sequencer
FILELIST  ?= timed_seq.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_MSG  ?= TEST OK

SOURCES := $(shell grep '\.sv$$' $(FILELIST)) $(wildcard test/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- test/tb_vectors.svh
	// columns: timestamp, earliest write cycle, address, data, expected bus address and data
	// dac samples are queued before the first command
	localparam int NUM_VEC    = 27;
	localparam int NUM_SAMPLE = 3;

	time_t     vec_ts       [NUM_VEC];
	time_t     vec_wr_at    [NUM_VEC];
	bus_addr_t vec_addr     [NUM_VEC];
	bus_data_t vec_data     [NUM_VEC];
	bus_addr_t vec_exp_addr [NUM_VEC];
	bus_data_t vec_exp_data [NUM_VEC];
	sample_t   dac_samples  [NUM_SAMPLE];
	int        vec_count;

	task automatic add_vector(input time_t ts, input time_t wr_at, input bus_addr_t addr,
			input bus_data_t data, input bus_addr_t exp_addr, input bus_data_t exp_data);
		vec_ts[vec_count]       = ts;
		vec_wr_at[vec_count]    = wr_at;
		vec_addr[vec_count]     = addr;
		vec_data[vec_count]     = data;
		vec_exp_addr[vec_count] = exp_addr;
		vec_exp_data[vec_count] = exp_data;
		vec_count++;
	endtask

	task automatic load_vectors();
		vec_count      = 0;
		dac_samples[0] = 16'h00a5;
		dac_samples[1] = 16'h8001;
		dac_samples[2] = 16'hbeef;
		// immediate commands, then the dac address with and without samples left
		add_vector(32'd0,   32'd0,   16'h0100, 32'h1000_0001, 16'h0100, 32'h1000_0001);
		add_vector(32'd0,   32'd0,   16'h0104, 32'h2000_0002, 16'h0104, 32'h2000_0002);
		add_vector(32'd0,   32'd0,   16'h0108, 32'hdead_beef, 16'h0108, 32'hdead_beef);
		add_vector(32'd0,   32'd0,   16'h0040, 32'h5555_0003, 16'h0040, 32'h0000_00a5);
		add_vector(32'd0,   32'd0,   16'h0200, 32'h0000_0004, 16'h0200, 32'h0000_0004);
		add_vector(32'd0,   32'd0,   16'h0040, 32'h5555_0005, 16'h0040, 32'h0000_8001);
		add_vector(32'd0,   32'd0,   16'h0040, 32'h5555_0006, 16'h0040, 32'h0000_beef);
		add_vector(32'd0,   32'd0,   16'h0040, 32'h7777_0007, 16'h0040, 32'h7777_0007);
		// future timestamps hold back the commands queued behind them
		add_vector(32'd300, 32'd100, 16'h0300, 32'h3000_0008, 16'h0300, 32'h3000_0008);
		add_vector(32'd0,   32'd0,   16'h0304, 32'h3000_0009, 16'h0304, 32'h3000_0009);
		add_vector(32'd0,   32'd0,   16'h0308, 32'h3000_000a, 16'h0308, 32'h3000_000a);
		add_vector(32'd320, 32'd0,   16'h030c, 32'h3200_000b, 16'h030c, 32'h3200_000b);
		add_vector(32'd0,   32'd0,   16'h0310, 32'h3000_000c, 16'h0310, 32'h3000_000c);
		// timestamps already in the past
		add_vector(32'd5,   32'd340, 16'h0314, 32'h0500_000d, 16'h0314, 32'h0500_000d);
		add_vector(32'd100, 32'd0,   16'h0318, 32'h1000_000e, 16'h0318, 32'h1000_000e);
		// far future command, then a burst that fills the command fifo
		add_vector(32'd600, 32'd380, 16'h0500, 32'h6000_000f, 16'h0500, 32'h6000_000f);
		add_vector(32'd0,   32'd0,   16'h0510, 32'ha5a5_0010, 16'h0510, 32'ha5a5_0010);
		add_vector(32'd0,   32'd0,   16'h0514, 32'h5a5a_0011, 16'h0514, 32'h5a5a_0011);
		add_vector(32'd0,   32'd0,   16'h0518, 32'h0f0f_0012, 16'h0518, 32'h0f0f_0012);
		add_vector(32'd0,   32'd0,   16'h051c, 32'hf0f0_0013, 16'h051c, 32'hf0f0_0013);
		add_vector(32'd0,   32'd0,   16'h0520, 32'h1234_0014, 16'h0520, 32'h1234_0014);
		add_vector(32'd0,   32'd0,   16'h0524, 32'h8765_0015, 16'h0524, 32'h8765_0015);
		add_vector(32'd0,   32'd0,   16'h0528, 32'h0000_0016, 16'h0528, 32'h0000_0016);
		add_vector(32'd0,   32'd0,   16'h052c, 32'hffff_0017, 16'h052c, 32'hffff_0017);
		add_vector(32'd0,   32'd0,   16'h0530, 32'hc3c3_0018, 16'h0530, 32'hc3c3_0018);
		add_vector(32'd0,   32'd0,   16'h0534, 32'h3c3c_0019, 16'h0534, 32'h3c3c_0019);
		add_vector(32'd0,   32'd0,   16'h0040, 32'h4040_001a, 16'h0040, 32'h4040_001a);
	endtask

//--- test/tb_timed_sequencer.sv
`timescale 1ns/100ps

module tb_timed_sequencer;

	import seq_pkg::*;

	localparam int CLK_HALF  = 5;
	localparam int DRIVE_DLY = 1;

	logic      clk;
	logic      rst;
	logic      cmd_wr;
	cmd_t      cmd_data;
	logic      cmd_full;
	logic      dac_wr;
	sample_t   dac_data;
	logic      dac_full;
	bus_addr_t bus_addr;
	bus_data_t bus_data;
	logic      bus_en;
	logic      bus_wr;

	`include "tb_vectors.svh"

	// mirrors the DUT time base from reset release
	time_t cycle_now;
	int    exp_idx_q [$];
	time_t exp_wr_q  [$];
	time_t prev_bus;
	int    issued;
	int    writes_done;
	logic  full_seen;

	timed_sequencer timed_sequencer_inst (
		.clk      (clk),
		.rst      (rst),
		.cmd_wr   (cmd_wr),
		.cmd_data (cmd_data),
		.cmd_full (cmd_full),
		.dac_wr   (dac_wr),
		.dac_data (dac_data),
		.dac_full (dac_full),
		.bus_addr (bus_addr),
		.bus_data (bus_data),
		.bus_en   (bus_en),
		.bus_wr   (bus_wr)
	);

	always #CLK_HALF clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_addr(input string name, input bus_addr_t got, input bus_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp));
	endtask

	task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp));
	endtask

	task automatic check_time(input string name, input time_t got, input time_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0t: %s = %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("FAIL at %0t: %s = %b, expected %b", $time, name, got, exp));
	endtask

	// inputs change a little after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	task automatic write_sample(input sample_t s);
		dac_wr   = 1'b1;
		dac_data = s;
		next_cycle();
		dac_wr = 1'b0;
	endtask

	task automatic write_command(input int idx);
		int gap;
		gap = $urandom_range(2, 0);
		repeat (gap) next_cycle();
		while (cycle_now < vec_wr_at[idx])
			next_cycle();
		// host holds off while the command fifo is full
		while (cmd_full) begin
			full_seen = 1'b1;
			next_cycle();
		end
		cmd_wr   = 1'b1;
		cmd_data = {vec_ts[idx], vec_data[idx], vec_addr[idx]};
		exp_idx_q.push_back(idx);
		exp_wr_q.push_back(cycle_now);
		writes_done++;
		next_cycle();
		cmd_wr = 1'b0;
	endtask

	// bus cycle is the latest of fetch latency, pipeline spacing and timestamp
	task automatic score_bus_write();
		int    idx;
		time_t wr_at;
		time_t exp_cycle;
		idx       = exp_idx_q.pop_front();
		wr_at     = exp_wr_q.pop_front();
		exp_cycle = wr_at + 32'd4;
		if (issued > 0 && prev_bus + 32'd2 > exp_cycle)
			exp_cycle = prev_bus + 32'd2;
		if (vec_ts[idx] != '0 && vec_ts[idx] + 32'd1 > exp_cycle)
			exp_cycle = vec_ts[idx] + 32'd1;
		check_addr("bus_addr", bus_addr, vec_exp_addr[idx]);
		check_data("bus_data", bus_data, vec_exp_data[idx]);
		if (vec_ts[idx] != '0 && cycle_now <= vec_ts[idx])
			abort_run($sformatf("command %0d reached the bus at cycle %0d, before its timestamp %0d",
				idx, cycle_now, vec_ts[idx]));
		check_time("bus write cycle", cycle_now, exp_cycle);
		prev_bus = cycle_now;
		issued++;
	endtask

	// bus monitor samples at the rising edge
	always @(posedge clk) begin
		if (rst) begin
			cycle_now = '0;
		end else begin
			if ($isunknown(bus_en) || $isunknown(bus_wr))
				abort_run("bus strobes are unknown after reset");
			if (bus_en !== bus_wr)
				abort_run("bus_en and bus_wr differ");
			// three samples never fill the sample fifo
			check_flag("dac_full", dac_full, 1'b0);
			if (bus_en) begin
				if (writes_done == 0)
					abort_run("bus write seen before any command was written");
				if (exp_idx_q.size() == 0)
					abort_run("bus write seen with no command pending");
				score_bus_write();
			end
			cycle_now = cycle_now + 32'd1;
		end
	end

	initial begin : watchdog
		time_t max_ts;
		int    limit;
		@(negedge rst);
		max_ts = '0;
		for (int i = 0; i < NUM_VEC; i++) begin
			if (vec_ts[i] > max_ts)
				max_ts = vec_ts[i];
		end
		limit = int'(max_ts) + 20 * NUM_VEC;
		repeat (limit) @(posedge clk);
		abort_run("the bus writes never completed before the time limit");
	end

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		cmd_wr      = 1'b0;
		cmd_data    = '0;
		dac_wr      = 1'b0;
		dac_data    = '0;
		prev_bus    = '0;
		issued      = 0;
		writes_done = 0;
		full_seen   = 1'b0;
		void'($urandom(32'h7518439a));
		load_vectors();

		repeat (3) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;

		for (int i = 0; i < NUM_SAMPLE; i++)
			write_sample(dac_samples[i]);
		for (int i = 0; i < NUM_VEC; i++)
			write_command(i);

		while (issued < NUM_VEC)
			next_cycle();
		// idle tail catches any stray bus write
		repeat (10) next_cycle();

		if (!full_seen)
			abort_run("command FIFO never reported full during the fill burst");
		else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

//--- timed_seq.f
+incdir+test
verilog/seq_pkg.sv
verilog/sync_fifo.sv
verilog/time_base.sv
verilog/cmd_decode.sv
verilog/cmd_execute.sv
verilog/bus_issue.sv
verilog/timed_sequencer.sv
test/tb_timed_sequencer.sv

//--- verilog/bus_issue.sv
`timescale 1ns/100ps

module bus_issue #(
	parameter seq_pkg::bus_addr_t DAC_ADDR = 16'h0040
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               release_pulse,
	input  seq_pkg::bus_addr_t slot_addr,
	input  seq_pkg::bus_data_t slot_data,
	input  logic               dac_empty,
	output logic               dac_rd,
	input  seq_pkg::sample_t   dac_dout,
	output seq_pkg::bus_addr_t bus_addr,
	output seq_pkg::bus_data_t bus_data,
	output logic               bus_en,
	output logic               bus_wr
);

	import seq_pkg::*;

	logic      dac_hit;
	logic      sample_sel;
	bus_data_t data_q;

	assign dac_hit = (slot_addr == DAC_ADDR);

	// sample arrives from the fifo in the bus cycle
	// empty sample fifo falls back to the command data
	assign dac_rd = release_pulse && dac_hit && !dac_empty;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			bus_en     <= 1'b0;
			bus_wr     <= 1'b0;
			sample_sel <= 1'b0;
		end else begin
			bus_en     <= release_pulse;
			bus_wr     <= release_pulse;
			sample_sel <= dac_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (release_pulse) begin
			bus_addr <= slot_addr;
			data_q   <= slot_data;
		end
	end

	// zero-extended sample or the command's own data
	assign bus_data = sample_sel ? {{(DATA_W - SAMPLE_W){1'b0}}, dac_dout} : data_q;

	// only write cycles on this bus
	a_en_is_wr: assert property (@(posedge clk) disable iff (rst) bus_en == bus_wr)
		else $error("bus_issue: bus_en and bus_wr differ");

endmodule

//--- verilog/cmd_decode.sv
`timescale 1ns/100ps

module cmd_decode (
	input  logic               clk,
	input  logic               rst,
	input  seq_pkg::cmd_t      cmd_dout,
	input  logic               cmd_empty,
	output logic               cmd_rd,
	input  logic               take,
	output logic               slot_valid,
	output seq_pkg::time_t     slot_time,
	output seq_pkg::bus_addr_t slot_addr,
	output seq_pkg::bus_data_t slot_data
);

	import seq_pkg::*;

	// read issued last cycle so the word is on cmd_dout now
	logic rd_pending;
	logic slot_free;

	// slot counts as free in the cycle it is being taken
	assign slot_free = !slot_valid || take;

	// one read in flight at most
	assign cmd_rd = slot_free && !cmd_empty && !rd_pending;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_pending <= 1'b0;
			slot_valid <= 1'b0;
		end else begin
			rd_pending <= cmd_rd;
			if (rd_pending)
				slot_valid <= 1'b1;
			else if (take)
				slot_valid <= 1'b0;
		end
	end

	// split the command word into its fields
	always_ff @(posedge clk) begin
		if (rd_pending) begin
			slot_time <= cmd_dout[TIME_LSB +: TIME_W];
			slot_data <= cmd_dout[DATA_LSB +: DATA_W];
			slot_addr <= cmd_dout[ADDR_LSB +: ADDR_W];
		end
	end

endmodule

//--- verilog/cmd_execute.sv
`timescale 1ns/100ps

module cmd_execute (
	input  logic           clk,
	input  logic           rst,
	input  logic           slot_valid,
	input  seq_pkg::time_t slot_time,
	input  seq_pkg::time_t now,
	output logic           release_pulse
);

	logic immediate;
	logic due;

	// zero timestamp skips the time compare
	assign immediate = (slot_time == '0);

	// past timestamps also count as due
	assign due = (now >= slot_time);

	assign release_pulse = slot_valid && (immediate || due);

	// release only fires on a held command, and the slot drains on that edge
	a_release_drains_slot: assert property (@(posedge clk) disable iff (rst)
		release_pulse |-> slot_valid ##1 !slot_valid)
		else $error("cmd_execute: slot still held after release");

endmodule

//--- verilog/seq_pkg.sv
package seq_pkg;

	// field widths
	localparam int TIME_W   = 32;
	localparam int DATA_W   = 32;
	localparam int ADDR_W   = 16;
	localparam int SAMPLE_W = 16;
	localparam int CMD_W    = TIME_W + DATA_W + ADDR_W;

	// command layout: time in the top bits, then data, address at the bottom
	localparam int ADDR_LSB = 0;
	localparam int DATA_LSB = ADDR_LSB + ADDR_W;
	localparam int TIME_LSB = DATA_LSB + DATA_W;

	// timestamp and current time
	typedef logic [TIME_W-1:0] time_t;

	// bus side
	typedef logic [ADDR_W-1:0] bus_addr_t;
	typedef logic [DATA_W-1:0] bus_data_t;

	// dac stream payload
	typedef logic [SAMPLE_W-1:0] sample_t;

	// full command word as written by the host
	typedef logic [CMD_W-1:0] cmd_t;

endpackage

//--- verilog/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 8
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     wr,
	input  payload_t din,
	input  logic     rd,
	output payload_t dout,
	output logic     empty,
	output logic     full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_rd)
				rd_ptr <= next_ptr(rd_ptr);
			// occupancy only moves when exactly one side is active
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	// storage and registered read port
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
		if (do_rd)
			dout <= mem[rd_ptr];
	end

	// producer must honour full, else the word is lost
	a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr |-> !full)
		else $error("sync_fifo: write while full, word dropped");

	// consumer must honour empty
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd |-> !empty)
		else $error("sync_fifo: read while empty");

endmodule

//--- verilog/time_base.sv
`timescale 1ns/100ps

module time_base (
	input  logic           clk,
	input  logic           rst,
	output seq_pkg::time_t now
);

	// cycle count since reset release
	// wraps silently after 2^32 cycles
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			now <= '0;
		else
			now <= now + 1'b1;
	end

endmodule

//--- verilog/timed_sequencer.sv
`timescale 1ns/100ps

module timed_sequencer #(
	parameter int                 CMD_DEPTH = 8,
	parameter int                 DAC_DEPTH = 16,
	parameter seq_pkg::bus_addr_t DAC_ADDR  = 16'h0040
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               cmd_wr,
	input  seq_pkg::cmd_t      cmd_data,
	output logic               cmd_full,
	input  logic               dac_wr,
	input  seq_pkg::sample_t   dac_data,
	output logic               dac_full,
	output seq_pkg::bus_addr_t bus_addr,
	output seq_pkg::bus_data_t bus_data,
	output logic               bus_en,
	output logic               bus_wr
);

	import seq_pkg::*;

	cmd_t      cmd_dout;
	logic      cmd_empty;
	logic      cmd_rd;
	sample_t   dac_dout;
	logic      dac_empty;
	logic      dac_rd;
	time_t     now;
	logic      slot_valid;
	time_t     slot_time;
	bus_addr_t slot_addr;
	bus_data_t slot_data;
	logic      release_pulse;

	// host command queue
	sync_fifo #(.payload_t(cmd_t), .DEPTH(CMD_DEPTH)) cmd_fifo_inst (
		.clk   (clk),
		.rst   (rst),
		.wr    (cmd_wr),
		.din   (cmd_data),
		.rd    (cmd_rd),
		.dout  (cmd_dout),
		.empty (cmd_empty),
		.full  (cmd_full)
	);

	// dac sample stream
	sync_fifo #(.payload_t(sample_t), .DEPTH(DAC_DEPTH)) dac_fifo_inst (
		.clk   (clk),
		.rst   (rst),
		.wr    (dac_wr),
		.din   (dac_data),
		.rd    (dac_rd),
		.dout  (dac_dout),
		.empty (dac_empty),
		.full  (dac_full)
	);

	time_base time_base_inst (
		.clk (clk),
		.rst (rst),
		.now (now)
	);

	// release doubles as the take strobe for the slot
	cmd_decode cmd_decode_inst (
		.clk        (clk),
		.rst        (rst),
		.cmd_dout   (cmd_dout),
		.cmd_empty  (cmd_empty),
		.cmd_rd     (cmd_rd),
		.take       (release_pulse),
		.slot_valid (slot_valid),
		.slot_time  (slot_time),
		.slot_addr  (slot_addr),
		.slot_data  (slot_data)
	);

	cmd_execute cmd_execute_inst (
		.clk           (clk),
		.rst           (rst),
		.slot_valid    (slot_valid),
		.slot_time     (slot_time),
		.now           (now),
		.release_pulse (release_pulse)
	);

	bus_issue #(.DAC_ADDR(DAC_ADDR)) bus_issue_inst (
		.clk           (clk),
		.rst           (rst),
		.release_pulse (release_pulse),
		.slot_addr     (slot_addr),
		.slot_data     (slot_data),
		.dac_empty     (dac_empty),
		.dac_rd        (dac_rd),
		.dac_dout      (dac_dout),
		.bus_addr      (bus_addr),
		.bus_data      (bus_data),
		.bus_en        (bus_en),
		.bus_wr        (bus_wr)
	);

endmodule
